//--- rtl/fp16_pkg.sv
// ----------------------------------------
// Half-precision adder shared definitions
// Format widths, special constants and
// the structs passed between stages
// ----------------------------------------

package fp16_pkg;

    // ----------------------------------------
    // Format widths
    // ----------------------------------------

    // Biased exponent field
    localparam int EXP_W = 5;
    // Stored fraction field
    localparam int MANT_W = 10;
    // Low bits kept while aligning the smaller operand
    localparam int GUARD_W = 14;
    // Hidden bit, fraction and guard bits
    localparam int ALIGN_MANT_W = MANT_W + 1 + GUARD_W;
    // Aligned significand plus carry bit
    localparam int SUM_W = ALIGN_MANT_W + 1;
    // Width of a bit index into the sum
    localparam int LEAD_W = $clog2(SUM_W);

    // ----------------------------------------
    // Operand word and special values
    // ----------------------------------------

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [MANT_W-1:0] frac;
    } fp16_t;

    // All-ones exponent marks infinity or NaN
    localparam logic [EXP_W-1:0] EXP_MAX = {EXP_W{1'b1}};

    // Quiet NaN, fraction MSB set
    localparam fp16_t QNAN = '{
        sign: 1'b0,
        exp:  EXP_MAX,
        frac: {1'b1, {(MANT_W-1){1'b0}}}
    };

    localparam fp16_t POS_ZERO = '{sign: 1'b0, exp: '0, frac: '0};
    localparam fp16_t NEG_ZERO = '{sign: 1'b1, exp: '0, frac: '0};

    // ----------------------------------------
    // Stage structs
    // ----------------------------------------

    // Per-operand classification
    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
    } fp16_class_t;

    // Bypass decision, zero_neg only for -0 + -0
    typedef struct packed {
        logic  hit;
        fp16_t value;
        logic  zero_neg;
    } special_t;

    // Operands after swap and alignment
    typedef struct packed {
        logic [EXP_W-1:0]        big_exp;
        logic                    sign;
        logic                    is_sub;
        logic [ALIGN_MANT_W-1:0] big_mant;
        logic [ALIGN_MANT_W-1:0] small_mant;
    } align_t;

    // First pipeline register contents
    typedef struct packed {
        logic [EXP_W-1:0] exp;
        logic             sign;
        logic [SUM_W-1:0] mant;
        special_t         special;
    } sum_t;

endpackage

//--- rtl/fp16_special.sv
// ----------------------------------------
// Operand classification and bypass select
// for NaN, infinity and zero operands
// ----------------------------------------

`timescale 1ns/1ps

module fp16_special (
    input  fp16_pkg::fp16_t    a,
    input  fp16_pkg::fp16_t    b,
    output fp16_pkg::special_t special
);
    import fp16_pkg::*;

    fp16_class_t cls_a;
    fp16_class_t cls_b;

    // Classify one operand from its raw fields
    function automatic fp16_class_t classify(input fp16_t v);
        fp16_class_t c;
        c.is_zero = (v.exp == '0) && (v.frac == '0);
        c.is_inf  = (v.exp == EXP_MAX) && (v.frac == '0);
        c.is_nan  = (v.exp == EXP_MAX) && (v.frac != '0);
        return c;
    endfunction

    assign cls_a = classify(a);
    assign cls_b = classify(b);

    always_comb begin
        special.hit      = 1'b0;
        special.value    = POS_ZERO;
        // Sign of an exact zero sum, set only for -0 + -0
        special.zero_neg = cls_a.is_zero && cls_b.is_zero && a.sign && b.sign;

        // Priority is NaN, then infinity, then zero
        if (cls_a.is_nan || cls_b.is_nan ||
            (cls_a.is_inf && cls_b.is_inf && (a.sign != b.sign))) begin
            special.hit   = 1'b1;
            special.value = QNAN;
        end else if (cls_a.is_inf) begin
            special.hit   = 1'b1;
            special.value = a;
        end else if (cls_b.is_inf) begin
            special.hit   = 1'b1;
            special.value = b;
        end else if (cls_a.is_zero && cls_b.is_zero) begin
            special.hit   = 1'b1;
            special.value = special.zero_neg ? NEG_ZERO : POS_ZERO;
        end else if (cls_a.is_zero) begin
            // Other operand passes unchanged, denormals included
            special.hit   = 1'b1;
            special.value = b;
        end else if (cls_b.is_zero) begin
            special.hit   = 1'b1;
            special.value = a;
        end
    end

endmodule

//--- rtl/fp16_align.sv
// ----------------------------------------
// Magnitude compare, operand swap and
// right shift of the smaller significand
// ----------------------------------------

`timescale 1ns/1ps

module fp16_align (
    input  fp16_pkg::fp16_t  a,
    input  fp16_pkg::fp16_t  b,
    output fp16_pkg::align_t aligned
);
    import fp16_pkg::*;

    // Significands with hidden bit restored
    logic [MANT_W:0] sig_a;
    logic [MANT_W:0] sig_b;

    // Denormals sit at the same scale as exponent 1
    logic [EXP_W-1:0] exp_eff_a;
    logic [EXP_W-1:0] exp_eff_b;

    logic             a_big;
    logic [EXP_W-1:0] small_exp;
    logic [EXP_W-1:0] exp_diff;
    logic [MANT_W:0]  big_sig;
    logic [MANT_W:0]  small_sig;

    assign sig_a = {(a.exp != '0), a.frac};
    assign sig_b = {(b.exp != '0), b.frac};

    assign exp_eff_a = (a.exp == '0) ? EXP_W'(1) : a.exp;
    assign exp_eff_b = (b.exp == '0) ? EXP_W'(1) : b.exp;

    // Exponent first, then fraction, ties keep a in front
    assign a_big = {a.exp, a.frac} >= {b.exp, b.frac};

    always_comb begin
        if (a_big) begin
            aligned.big_exp = exp_eff_a;
            aligned.sign    = a.sign;
            small_exp       = exp_eff_b;
            big_sig         = sig_a;
            small_sig       = sig_b;
        end else begin
            aligned.big_exp = exp_eff_b;
            aligned.sign    = b.sign;
            small_exp       = exp_eff_a;
            big_sig         = sig_b;
            small_sig       = sig_a;
        end
    end

    // Never negative after the swap
    assign exp_diff = aligned.big_exp - small_exp;

    // Guard bits appended below the fraction
    assign aligned.big_mant = {big_sig, {GUARD_W{1'b0}}};

    // Bits shifted past the guard bits are dropped
    assign aligned.small_mant = {small_sig, {GUARD_W{1'b0}}} >> exp_diff;

    // Effective subtraction when the signs differ
    assign aligned.is_sub = a.sign ^ b.sign;

endmodule

//--- rtl/fp16_addsub.sv
// ----------------------------------------
// Stage 1 register, significand add or
// subtract with the bypass carried along
// ----------------------------------------

`timescale 1ns/1ps

module fp16_addsub (
    input  logic                clk,
    input  logic                rst_n,
    input  fp16_pkg::align_t    aligned,
    input  fp16_pkg::special_t  special,
    output fp16_pkg::sum_t      sum
);
    import fp16_pkg::*;

    logic [SUM_W-1:0] mant_d;
    logic             sign_d;

    always_comb begin
        if (!aligned.is_sub) begin
            // Same sign, carry bit may come up
            mant_d = {1'b0, aligned.big_mant} + {1'b0, aligned.small_mant};
            sign_d = aligned.sign;
        end else if (aligned.big_mant >= aligned.small_mant) begin
            mant_d = {1'b0, aligned.big_mant} - {1'b0, aligned.small_mant};
            sign_d = aligned.sign;
        end else begin
            // Reverse order, result takes the other sign
            mant_d = {1'b0, aligned.small_mant} - {1'b0, aligned.big_mant};
            sign_d = ~aligned.sign;
        end
    end

    // ----------------------------------------
    // Pipeline register
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else begin
            sum.exp     <= aligned.big_exp;
            sum.sign    <= sign_d;
            sum.mant    <= mant_d;
            // Bypass stays with its own operands
            sum.special <= special;
        end
    end

    // Every field is driven once reset is released
    sum_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(sum))
        else $error("Stage 1 register holds unknown bits");

endmodule

//--- rtl/fp16_normalize.sv
// ----------------------------------------
// Stage 2 normalize and pack
// Leading-one search, range limits, zero
// sign, bypass select, output register
// ----------------------------------------

`timescale 1ns/1ps

module fp16_normalize (
    input  logic            clk,
    input  logic            rst_n,
    input  fp16_pkg::sum_t  sum,
    output fp16_pkg::fp16_t result
);
    import fp16_pkg::*;

    // Position of the hidden bit in the sum
    localparam logic [LEAD_W-1:0] HIDDEN_POS = LEAD_W'(ALIGN_MANT_W - 1);

    logic [LEAD_W-1:0]       lead_pos;
    logic [LEAD_W-1:0]       left_shift;
    logic [SUM_W-1:0]        norm_mant;
    logic signed [EXP_W+1:0] norm_exp;
    fp16_t                   arith;
    fp16_t                   result_d;

    // Index of the highest set bit, zero for an all-zero sum
    function automatic logic [LEAD_W-1:0] lead_one(input logic [SUM_W-1:0] v);
        logic [LEAD_W-1:0] pos;
        pos = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (v[i]) begin
                pos = LEAD_W'(i);
            end
        end
        return pos;
    endfunction

    assign lead_pos   = lead_one(sum.mant);
    assign left_shift = HIDDEN_POS - lead_pos;

    // ----------------------------------------
    // Normalizing shift
    // ----------------------------------------

    always_comb begin
        if (lead_pos > HIDDEN_POS) begin
            // Carry out, one step right
            norm_mant = sum.mant >> 1;
            norm_exp  = $signed({2'b00, sum.exp}) + 7'sd1;
        end else begin
            // Cancellation or denormal, move leading one up
            norm_mant = sum.mant << left_shift;
            norm_exp  = $signed({2'b00, sum.exp}) - $signed({2'b00, left_shift});
        end
    end

    // ----------------------------------------
    // Range limits and packing
    // ----------------------------------------

    always_comb begin
        arith.sign = sum.sign;
        arith.exp  = norm_exp[EXP_W-1:0];
        // Fraction just below the hidden bit, rest truncated
        arith.frac = norm_mant[ALIGN_MANT_W-2 -: MANT_W];

        if (sum.mant == '0) begin
            // Exact zero from cancellation is always positive
            arith = POS_ZERO;
        end else if (norm_exp >= $signed({2'b00, EXP_MAX})) begin
            // Overflow to signed infinity
            arith.exp  = EXP_MAX;
            arith.frac = '0;
        end else if (norm_exp <= 0) begin
            // Underflow flushes, no denormal results
            arith = POS_ZERO;
        end
    end

    assign result_d = sum.special.hit ? sum.special.value : arith;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= POS_ZERO;
        end else begin
            result <= result_d;
        end
    end

    // Arithmetic path never packs a denormal
    // Bypassed operands may, so the check skips them
    no_denorm_out: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((result.exp == '0) && !$past(sum.special.hit)) |-> (result.frac == '0))
        else $error("Arithmetic path produced a denormal result");

endmodule

//--- rtl/fp16_add.sv
// ----------------------------------------
// Half-precision adder top level
// Two-register pipeline, one pair per clk
// ----------------------------------------

`timescale 1ns/1ps

module fp16_add (
    input  logic            clk,
    input  logic            rst_n,
    input  fp16_pkg::fp16_t a,
    input  fp16_pkg::fp16_t b,
    output fp16_pkg::fp16_t result
);
    import fp16_pkg::*;

    // Combinational front end
    special_t special;
    align_t   aligned;

    // Stage 1 register
    sum_t sum;

    // NaN, infinity and zero bypass
    fp16_special u_special (
        .a       (a),
        .b       (b),
        .special (special)
    );

    // Swap and align, in parallel with the bypass
    fp16_align u_align (
        .a       (a),
        .b       (b),
        .aligned (aligned)
    );

    // First edge
    fp16_addsub u_addsub (
        .clk     (clk),
        .rst_n   (rst_n),
        .aligned (aligned),
        .special (special),
        .sum     (sum)
    );

    // Second edge, drives result
    fp16_normalize u_normalize (
        .clk    (clk),
        .rst_n  (rst_n),
        .sum    (sum),
        .result (result)
    );

endmodule

//--- verification/fp16_add_vectors.svh
// ----------------------------------------
// Operand pairs and expected sums for the
// half-precision adder testbench
// ----------------------------------------

`ifndef FP16_ADD_VECTORS_SVH
`define FP16_ADD_VECTORS_SVH

// Columns are name, a, b, expected result
task automatic load_vectors();
    // Same-sign additions
    add_vector("same_sign_1p5_1p5",      16'h3E00, 16'h3E00, 16'h4200);
    add_vector("same_sign_1_1",          16'h3C00, 16'h3C00, 16'h4000);
    add_vector("same_sign_1_2",          16'h3C00, 16'h4000, 16'h4200);
    add_vector("same_sign_neg",          16'hC000, 16'hC200, 16'hC500);
    add_vector("pi_plus_one",            16'h4248, 16'h3C00, 16'h4424);
    add_vector("denorm_plus_normal",     16'h0200, 16'h0400, 16'h0600);
    add_vector("denorm_plus_denorm",     16'h0200, 16'h0200, 16'h0400);
    // Opposite signs and cancellation
    add_vector("sub_b_larger",           16'h3C00, 16'hC000, 16'hBC00);
    add_vector("sub_a_larger",           16'h4000, 16'hBC00, 16'h3C00);
    add_vector("sub_100_10",             16'h5640, 16'hC900, 16'h55A0);
    add_vector("cancel_large",           16'h3C01, 16'hBC00, 16'h1400);
    add_vector("cancel_exact",           16'h3C00, 16'hBC00, 16'h0000);
    add_vector("cancel_exact_neg_first", 16'hBC00, 16'h3C00, 16'h0000);
    // NaN and infinity
    add_vector("nan_a",                  16'h7E00, 16'h3C00, 16'h7E00);
    add_vector("nan_b_payload",          16'h3C00, 16'h7C01, 16'h7E00);
    add_vector("nan_negative",           16'hFE00, 16'hC000, 16'h7E00);
    add_vector("inf_minus_inf",          16'h7C00, 16'hFC00, 16'h7E00);
    add_vector("inf_plus_finite",        16'h7C00, 16'h3C00, 16'h7C00);
    add_vector("finite_plus_neg_inf",    16'h4000, 16'hFC00, 16'hFC00);
    add_vector("inf_plus_inf",           16'h7C00, 16'h7C00, 16'h7C00);
    // Zeros
    add_vector("neg_zero_neg_zero",      16'h8000, 16'h8000, 16'h8000);
    add_vector("pos_zero_neg_zero",      16'h0000, 16'h8000, 16'h0000);
    add_vector("neg_zero_pos_zero",      16'h8000, 16'h0000, 16'h0000);
    add_vector("zero_plus_x",            16'h0000, 16'h4248, 16'h4248);
    add_vector("neg_x_plus_neg_zero",    16'hC500, 16'h8000, 16'hC500);
    add_vector("zero_plus_denorm",       16'h0000, 16'h0001, 16'h0001);
    // Range limits and truncation
    add_vector("max_plus_max",           16'h7BFF, 16'h7BFF, 16'h7C00);
    add_vector("neg_max_plus_neg_max",   16'hFBFF, 16'hFBFF, 16'hFC00);
    add_vector("tiny_diff_flush",        16'h0401, 16'h8400, 16'h0000);
    add_vector("tiny_diff_flush_neg",    16'h0400, 16'h8401, 16'h0000);
    add_vector("trunc_1_plus_2m12",      16'h3C00, 16'h0C00, 16'h3C00);
    add_vector("trunc_third_plus_1",     16'h3555, 16'h3C00, 16'h3D55);
    add_vector("trunc_on_carry",         16'h3C01, 16'h3C00, 16'h4000);
endtask

`endif

//--- verification/fp16_add_tb.sv
// ----------------------------------------
// Testbench for the half-precision adder
// Shuffled vector passes, pipelined check
// ----------------------------------------

`timescale 1ns/1ps

module fp16_add_tb;
    import fp16_pkg::*;

    localparam int          CLK_PERIOD = 20;
    localparam int          NUM_PASSES = 2;
    localparam int unsigned SEED       = 32'h4e0eb0ec;

    // Operands and expected sum of one table row
    typedef struct packed {
        fp16_t a;
        fp16_t b;
        fp16_t expected;
    } vector_t;

    logic  clk;
    logic  rst_n;
    fp16_t a;
    fp16_t b;
    fp16_t result;

    // Vector table and the issue order of one pass
    string   vec_name[$];
    vector_t vec_q[$];
    int      order[$];

    // Row index following the operands through both registers
    logic issue_valid;
    int   issue_row;
    logic track_valid [2];
    int   track_row [2];

    int   pass_count;
    int   fail_count;
    int   check_count;
    int   total_checks;
    logic loaded;

    fp16_add dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .a      (a),
        .b      (b),
        .result (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_vector(input string name, input fp16_t op_a, input fp16_t op_b,
                              input fp16_t expected);
        vec_name.push_back(name);
        vec_q.push_back('{a: op_a, b: op_b, expected: expected});
    endtask

    `include "fp16_add_vectors.svh"

    // Fisher-Yates over the row indices
    task automatic shuffle_order();
        int j;
        int tmp;
        order.delete();
        for (int i = 0; i < vec_q.size(); i++) begin
            order.push_back(i);
        end
        for (int i = vec_q.size() - 1; i > 0; i--) begin
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
    endtask

    // Exact bit compare of one result word
    task automatic check_fp16(input string name, input fp16_t expected, input fp16_t actual);
        check_count++;
        if (actual === expected) begin
            pass_count++;
            $display("[PASS] %0t ns %s: %h", $time, name, actual);
        end else begin
            fail_count++;
            $display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // ----------------------------------------
    // Pipeline tracking and checking
    // ----------------------------------------

    // Mirrors the two DUT registers
    always @(posedge clk) begin
        track_valid[0] <= issue_valid;
        track_row[0]   <= issue_row;
        track_valid[1] <= track_valid[0];
        track_row[1]   <= track_row[0];
    end

    // Result is stable at the falling edge after its second rising edge
    initial begin
        forever begin
            @(negedge clk);
            if (track_valid[1] === 1'b1) begin
                check_fp16(vec_name[track_row[1]], vec_q[track_row[1]].expected, result);
            end
        end
    end

    // Watchdog sized from the number of issued rows
    initial begin
        wait (loaded === 1'b1);
        #((NUM_PASSES * vec_q.size() + 10) * CLK_PERIOD);
        $display("Simulation timed out after %0t ns with %0d of %0d checks done",
                 $time, check_count, total_checks);
        $display("Some tests failed");
        $finish;
    end

    // ----------------------------------------
    // Reset and stimulus
    // ----------------------------------------

    initial begin
        int unsigned seed;
        seed           = SEED;
        clk            = 1'b0;
        rst_n          = 1'b0;
        a              = POS_ZERO;
        b              = POS_ZERO;
        issue_valid    = 1'b0;
        issue_row      = 0;
        track_valid[0] = 1'b0;
        track_valid[1] = 1'b0;
        track_row[0]   = 0;
        track_row[1]   = 0;
        pass_count     = 0;
        fail_count     = 0;
        check_count    = 0;
        loaded         = 1'b0;
        void'($urandom(seed));

        load_vectors();
        total_checks = NUM_PASSES * vec_q.size();
        loaded       = 1'b1;

        // Two cycles of reset, released away from the rising edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // One new pair every cycle, no gaps
        for (int p = 0; p < NUM_PASSES; p++) begin
            shuffle_order();
            for (int i = 0; i < order.size(); i++) begin
                @(negedge clk);
                a           = vec_q[order[i]].a;
                b           = vec_q[order[i]].b;
                issue_row   = order[i];
                issue_valid = 1'b1;
            end
        end
        @(negedge clk);
        issue_valid = 1'b0;
        a           = POS_ZERO;
        b           = POS_ZERO;

        wait (check_count == total_checks);
        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+verification
rtl/fp16_pkg.sv
rtl/fp16_special.sv
rtl/fp16_align.sv
rtl/fp16_addsub.sv
rtl/fp16_normalize.sv
rtl/fp16_add.sv
verification/fp16_add_tb.sv

//--- Bender.yml
package:
  name: fp16_add

sources:
  # Package first, then the stages, then the top level
  - files:
      - rtl/fp16_pkg.sv
      - rtl/fp16_special.sv
      - rtl/fp16_align.sv
      - rtl/fp16_addsub.sv
      - rtl/fp16_normalize.sv
      - rtl/fp16_add.sv

  # Testbench and its vector table
  - target: test
    include_dirs:
      - verification
    files:
      - verification/fp16_add_tb.sv
